//--- fifo_async_top.f
source/fifo_async_pkg.sv
source/gray_counter.sv
source/gray_ptr_sync.sv
source/fifo_dp_ram.sv
source/fifo_async.sv
source/fifo_async_top.sv
testbench/fifo_checker.sv
testbench/tb_fifo_async.sv

//--- testbench/tb_fifo_async.sv
`timescale 1ns/1ps

module tb_fifo_async;

  localparam int DATA_W  = 16;
  localparam int ADDR_W  = 4;
  localparam int DEPTH   = 16;
  localparam int SEED    = 81;
  localparam int TIMEOUT = 64;
  localparam int N_ROWS  = 5;

  // writes, pattern seed, reads, overlap, random, held writes, held reads, final level
  typedef struct packed {
    logic [7:0]  n_wr;
    logic [15:0] seed;
    logic [7:0]  n_rd;
    logic        overlap;
    logic        rnd;
    logic [7:0]  hold_wr;
    logic [7:0]  hold_rd;
    logic [7:0]  exp_lvl;
  } row_t;

  row_t rows [N_ROWS];

  logic              w_clk;
  logic              r_clk;
  logic              rst;
  logic              w_en;
  logic [DATA_W-1:0] w_data;
  logic              w_full;
  logic              w_empty;
  logic [ADDR_W:0]   w_level;
  logic              r_en;
  logic [DATA_W-1:0] r_data;
  logic              r_empty;
  logic              r_full;
  logic [ADDR_W:0]   r_level;
  int                data_errs;
  int                flag_errs;
  int                tmo_cnt;

  fifo_async_top #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) dut0 (
    .w_clk_i   (w_clk),
    .r_clk_i   (r_clk),
    .rst_i     (rst),
    .w_en_i    (w_en),
    .w_data_i  (w_data),
    .w_full_o  (w_full),
    .w_empty_o (w_empty),
    .w_level_o (w_level),
    .r_en_i    (r_en),
    .r_data_o  (r_data),
    .r_empty_o (r_empty),
    .r_full_o  (r_full),
    .r_level_o (r_level)
  );

  fifo_checker #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) chk0 (
    .w_clk_i    (w_clk),
    .r_clk_i    (r_clk),
    .rst_i      (rst),
    .w_en_i     (w_en),
    .w_data_i   (w_data),
    .w_full_i   (w_full),
    .w_empty_i  (w_empty),
    .w_level_i  (w_level),
    .r_en_i     (r_en),
    .r_data_i   (r_data),
    .r_empty_i  (r_empty),
    .r_full_i   (r_full),
    .r_level_i  (r_level),
    .data_err_o (data_errs),
    .flag_err_o (flag_errs)
  );

  initial begin
    w_clk = 1'b0;
    forever #50 w_clk = ~w_clk;
  end

  // read clock offset by 30 ns
  initial begin
    r_clk = 1'b0;
    #30;
    forever #50 r_clk = ~r_clk;
  end

  task automatic write_words(input int n, input int seed, input bit rnd);
    int i;
    int waited;
    i = 0;
    waited = 0;
    while (i < n) begin
      @(negedge w_clk);
      if (rnd && ($urandom % 4 == 0)) begin
        w_en = 1'b0;
      end else if (!w_full) begin
        w_en   = 1'b1;
        w_data = rnd ? DATA_W'($urandom) : DATA_W'(seed + i);
        i++;
        waited = 0;
      end else begin
        w_en = 1'b0;
        waited++;
        if (waited > TIMEOUT) begin
          $display("timeout: w_full_o stayed high, %0d writes left", n - i);
          tmo_cnt++;
          break;
        end
      end
    end
    @(negedge w_clk);
    w_en = 1'b0;
  endtask

  task automatic read_words(input int n, input bit rnd);
    int i;
    int waited;
    i = 0;
    waited = 0;
    while (i < n) begin
      @(negedge r_clk);
      if (rnd && ($urandom % 4 == 0)) begin
        r_en = 1'b0;
      end else if (!r_empty) begin
        r_en = 1'b1;
        i++;
        waited = 0;
      end else begin
        r_en = 1'b0;
        waited++;
        if (waited > TIMEOUT) begin
          $display("timeout: r_empty_o stayed high, %0d reads left", n - i);
          tmo_cnt++;
          break;
        end
      end
    end
    @(negedge r_clk);
    r_en = 1'b0;
  endtask

  // requests while the flag blocks them must be ignored
  task automatic hold_writes(input int n);
    if (n > 0) begin
      for (int k = 0; k < n; k++) begin
        @(negedge w_clk);
        w_en   = 1'b1;
        w_data = DATA_W'(16'hdead ^ k);
      end
      @(negedge w_clk);
      w_en = 1'b0;
    end
  endtask

  task automatic hold_reads(input int n);
    if (n > 0) begin
      repeat (n) begin
        @(negedge r_clk);
        r_en = 1'b1;
      end
      @(negedge r_clk);
      r_en = 1'b0;
    end
  endtask

  task automatic wait_settle(input int exp_lvl);
    int waited;
    waited = 0;
    @(negedge w_clk);
    while ((w_level !== exp_lvl || r_level !== exp_lvl) && waited < TIMEOUT) begin
      @(negedge w_clk);
      waited++;
    end
    if (w_level !== exp_lvl || r_level !== exp_lvl) begin
      $display("timeout: levels did not settle to %0d", exp_lvl);
      tmo_cnt++;
    end
  endtask

  task automatic run_row(input row_t row);
    if (row.overlap) begin
      fork
        write_words(row.n_wr, row.seed, row.rnd);
        read_words(row.n_rd, row.rnd);
      join
    end else begin
      write_words(row.n_wr, row.seed, row.rnd);
      read_words(row.n_rd, row.rnd);
    end
    wait_settle(row.exp_lvl);
    hold_writes(row.hold_wr);
    hold_reads(row.hold_rd);
    wait_settle(row.exp_lvl);
    chk0.check_levels(row.exp_lvl);
  endtask

  // nothing in the run may take this long
  initial begin
    #500000;
    $display("simulation ran too long and was stopped");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int dummy;
    rst     = 1'b1;
    w_en    = 1'b0;
    w_data  = '0;
    r_en    = 1'b0;
    tmo_cnt = 0;
    dummy   = $urandom(SEED);
    // fill, drain, partial, overlapped, random streaming
    rows[0] = '{8'(DEPTH), 16'h1000, 8'd0, 1'b0, 1'b0, 8'd4, 8'd0, 8'(DEPTH)};
    rows[1] = '{8'd0, 16'h0000, 8'(DEPTH), 1'b0, 1'b0, 8'd0, 8'd4, 8'd0};
    rows[2] = '{8'd10, 16'h2000, 8'd6, 1'b0, 1'b0, 8'd0, 8'd0, 8'd4};
    rows[3] = '{8'd8, 16'h3000, 8'd12, 1'b1, 1'b0, 8'd0, 8'd0, 8'd0};
    rows[4] = '{8'd60, 16'h0000, 8'd60, 1'b1, 1'b1, 8'd0, 8'd0, 8'd0};
    repeat (2) @(negedge w_clk);
    rst = 1'b0;
    chk0.check_levels(0);
    for (int i = 0; i < N_ROWS; i++) begin
      run_row(rows[i]);
    end
    @(negedge w_clk);
    $display("errors: data %0d, level and flag %0d, timeout %0d",
             data_errs, flag_errs, tmo_cnt);
    if (data_errs + flag_errs + tmo_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- testbench/fifo_checker.sv
`timescale 1ns/1ps

module fifo_checker #(
  parameter int DATA_W = 16,
  parameter int ADDR_W = 4
) (
  input  logic              w_clk_i,
  input  logic              r_clk_i,
  input  logic              rst_i,
  input  logic              w_en_i,
  input  logic [DATA_W-1:0] w_data_i,
  input  logic              w_full_i,
  input  logic              w_empty_i,
  input  logic [ADDR_W:0]   w_level_i,
  input  logic              r_en_i,
  input  logic [DATA_W-1:0] r_data_i,
  input  logic              r_empty_i,
  input  logic              r_full_i,
  input  logic [ADDR_W:0]   r_level_i,
  output int                data_err_o,
  output int                flag_err_o
);

  localparam int DEPTH = 2 ** ADDR_W;

  // words written and not yet read, oldest first
  logic [DATA_W-1:0] sb_q [$];
  logic [DATA_W-1:0] exp_data;
  logic [DATA_W-1:0] last_data;
  logic              rd_pend;
  logic              have_data;

  initial begin
    data_err_o = 0;
    flag_err_o = 0;
    rd_pend    = 1'b0;
    have_data  = 1'b0;
  end

  task automatic compare_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
      flag_err_o++;
    end
  endtask

  // both domains at rest, flags follow from the expected level
  task automatic check_levels(input int exp_level);
    compare_val("w_level_o", w_level_i, exp_level);
    compare_val("r_level_o", r_level_i, exp_level);
    compare_val("w_empty_o", w_empty_i, exp_level == 0);
    compare_val("r_empty_o", r_empty_i, exp_level == 0);
    compare_val("w_full_o", w_full_i, exp_level == DEPTH);
    compare_val("r_full_o", r_full_i, exp_level == DEPTH);
  endtask

  always @(posedge w_clk_i) begin
    if (!rst_i) begin
      if (w_en_i && !w_full_i) begin
        sb_q.push_back(w_data_i);
      end
      if (w_level_i > DEPTH) begin
        $display("error: w_level_o above depth, got 0x%h", w_level_i);
        flag_err_o++;
      end
    end
  end

  always @(posedge r_clk_i) begin
    if (!rst_i) begin
      if (r_en_i && !r_empty_i) begin
        if (sb_q.size() == 0) begin
          $display("read accepted while no written word was waiting at %0t", $time);
          data_err_o++;
        end else begin
          exp_data = sb_q.pop_front();
          rd_pend  = 1'b1;
        end
      end
      if (r_level_i > DEPTH) begin
        $display("error: r_level_o above depth, got 0x%h", r_level_i);
        flag_err_o++;
      end
    end
  end

  // registered read data is settled by the falling edge
  always @(negedge r_clk_i) begin
    if (rd_pend) begin
      if (r_data_i !== exp_data) begin
        $display("error: r_data_o expected 0x%h got 0x%h at %0t", exp_data, r_data_i, $time);
        data_err_o++;
      end
      last_data = r_data_i;
      have_data = 1'b1;
      rd_pend   = 1'b0;
    end else if (have_data && r_data_i !== last_data) begin
      $display("error: r_data_o changed without a read, expected 0x%h got 0x%h",
               last_data, r_data_i);
      data_err_o++;
    end
  end

endmodule

//--- source/fifo_async_top.sv
`timescale 1ns/1ps

module fifo_async_top
  import fifo_async_pkg::*;
  #(
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
  )
  (
    input  logic              w_clk_i,
    input  logic              r_clk_i,
    input  logic              rst_i,

    input  logic              w_en_i,
    input  logic [DATA_W-1:0] w_data_i,
    output logic              w_full_o,
    output logic              w_empty_o,
    output logic [ADDR_W:0]   w_level_o,

    input  logic              r_en_i,
    output logic [DATA_W-1:0] r_data_o,
    output logic              r_empty_o,
    output logic              r_full_o,
    output logic [ADDR_W:0]   r_level_o
  );

  // memory port between control and ram
  logic              mem_w_en;
  logic [ADDR_W-1:0] mem_w_addr;
  logic [DATA_W-1:0] mem_w_data;
  logic              mem_r_en;
  logic [ADDR_W-1:0] mem_r_addr;
  logic [DATA_W-1:0] mem_r_data;

  fifo_async #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) fifo0 (
    .w_clk_i      (w_clk_i),
    .r_clk_i      (r_clk_i),
    .rst_i        (rst_i),
    .w_en_i       (w_en_i),
    .w_data_i     (w_data_i),
    .w_full_o     (w_full_o),
    .w_empty_o    (w_empty_o),
    .w_level_o    (w_level_o),
    .r_en_i       (r_en_i),
    .r_data_o     (r_data_o),
    .r_empty_o    (r_empty_o),
    .r_full_o     (r_full_o),
    .r_level_o    (r_level_o),
    .mem_w_en_o   (mem_w_en),
    .mem_w_addr_o (mem_w_addr),
    .mem_w_data_o (mem_w_data),
    .mem_r_en_o   (mem_r_en),
    .mem_r_addr_o (mem_r_addr),
    .mem_r_data_i (mem_r_data)
  );

  fifo_dp_ram #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W)
  ) ram0 (
    .w_clk_i  (w_clk_i),
    .w_en_i   (mem_w_en),
    .w_addr_i (mem_w_addr),
    .w_data_i (mem_w_data),
    .r_clk_i  (r_clk_i),
    .r_en_i   (mem_r_en),
    .r_addr_i (mem_r_addr),
    .r_data_o (mem_r_data)
  );

endmodule

//--- source/fifo_async.sv
`timescale 1ns/1ps

module fifo_async
  import fifo_async_pkg::*;
  #(
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
  )
  (
    input  logic              w_clk_i,
    input  logic              r_clk_i,
    input  logic              rst_i,

    // write side
    input  logic              w_en_i,
    input  logic [DATA_W-1:0] w_data_i,
    output logic              w_full_o,
    output logic              w_empty_o,
    output logic [ADDR_W:0]   w_level_o,

    // read side
    input  logic              r_en_i,
    output logic [DATA_W-1:0] r_data_o,
    output logic              r_empty_o,
    output logic              r_full_o,
    output logic [ADDR_W:0]   r_level_o,

    // memory port
    output logic              mem_w_en_o,
    output logic [ADDR_W-1:0] mem_w_addr_o,
    output logic [DATA_W-1:0] mem_w_data_o,
    output logic              mem_r_en_o,
    output logic [ADDR_W-1:0] mem_r_addr_o,
    input  logic [DATA_W-1:0] mem_r_data_i
  );

  localparam int PTR_W = ADDR_W + 1;
  localparam logic [ADDR_W:0] DEPTH = {1'b1, {ADDR_W{1'b0}}};

  // pointers, prefix gives the domain they live in
  logic [PTR_W-1:0] w_wptr_bin;
  logic [PTR_W-1:0] w_wptr_gray;
  logic [PTR_W-1:0] w_rptr_bin;
  logic [PTR_W-1:0] r_rptr_bin;
  logic [PTR_W-1:0] r_rptr_gray;
  logic [PTR_W-1:0] r_wptr_bin;

  logic w_en_int;
  logic r_en_int;

  // requests are dropped while the blocking flag is up
  assign w_en_int = w_en_i & ~w_full_o;
  assign r_en_int = r_en_i & ~r_empty_o;

  gray_counter #(
    .PTR_W (PTR_W)
  ) w_ptr_cnt0 (
    .clk_i  (w_clk_i),
    .rst_i  (rst_i),
    .inc_i  (w_en_int),
    .bin_o  (w_wptr_bin),
    .gray_o (w_wptr_gray)
  );

  gray_counter #(
    .PTR_W (PTR_W)
  ) r_ptr_cnt0 (
    .clk_i  (r_clk_i),
    .rst_i  (rst_i),
    .inc_i  (r_en_int),
    .bin_o  (r_rptr_bin),
    .gray_o (r_rptr_gray)
  );

  // write pointer into the read domain
  gray_ptr_sync #(
    .PTR_W (PTR_W)
  ) wptr_to_r_sync0 (
    .clk_i  (r_clk_i),
    .rst_i  (rst_i),
    .gray_i (w_wptr_gray),
    .bin_o  (r_wptr_bin)
  );

  // read pointer into the write domain
  gray_ptr_sync #(
    .PTR_W (PTR_W)
  ) rptr_to_w_sync0 (
    .clk_i  (w_clk_i),
    .rst_i  (rst_i),
    .gray_i (r_rptr_gray),
    .bin_o  (w_rptr_bin)
  );

  // levels lag the foreign pointer, so they err on the safe side
  assign w_level_o = w_wptr_bin - w_rptr_bin;
  assign r_level_o = r_wptr_bin - r_rptr_bin;

  assign w_empty_o = (w_level_o == '0);
  assign w_full_o  = (w_level_o == DEPTH);
  assign r_empty_o = (r_level_o == '0);
  assign r_full_o  = (r_level_o == DEPTH);

  // memory addresses drop the wrap bit
  assign mem_w_en_o   = w_en_int;
  assign mem_w_addr_o = w_wptr_bin[ADDR_W-1:0];
  assign mem_w_data_o = w_data_i;
  assign mem_r_en_o   = r_en_int;
  assign mem_r_addr_o = r_rptr_bin[ADDR_W-1:0];
  assign r_data_o     = mem_r_data_i;

  a_w_level_max: assert property (
    @(posedge w_clk_i) disable iff (rst_i) w_level_o <= DEPTH
  ) else $error("fifo_async: w_level_o above depth");

  a_w_no_adv_full: assert property (
    @(posedge w_clk_i) disable iff (rst_i) w_full_o |=> $stable(w_wptr_bin)
  ) else $error("fifo_async: write pointer moved while full");

  a_r_level_max: assert property (
    @(posedge r_clk_i) disable iff (rst_i) r_level_o <= DEPTH
  ) else $error("fifo_async: r_level_o above depth");

  a_r_no_adv_empty: assert property (
    @(posedge r_clk_i) disable iff (rst_i) r_empty_o |=> $stable(r_rptr_bin)
  ) else $error("fifo_async: read pointer moved while empty");

endmodule

//--- source/fifo_dp_ram.sv
`timescale 1ns/1ps

module fifo_dp_ram
  import fifo_async_pkg::*;
  #(
    parameter int DATA_W = DEF_DATA_W,
    parameter int ADDR_W = DEF_ADDR_W
  )
  (
    input  logic              w_clk_i,
    input  logic              w_en_i,
    input  logic [ADDR_W-1:0] w_addr_i,
    input  logic [DATA_W-1:0] w_data_i,
    input  logic              r_clk_i,
    input  logic              r_en_i,
    input  logic [ADDR_W-1:0] r_addr_i,
    output logic [DATA_W-1:0] r_data_o
  );

  logic [DATA_W-1:0] mem [2**ADDR_W];

  // write port
  always_ff @(posedge w_clk_i) begin
    if (w_en_i) begin
      mem[w_addr_i] <= w_data_i;
    end
  end

  // registered read, output holds between enabled reads
  always_ff @(posedge r_clk_i) begin
    if (r_en_i) begin
      r_data_o <= mem[r_addr_i];
    end
  end

endmodule

//--- source/gray_ptr_sync.sv
`timescale 1ns/1ps

module gray_ptr_sync
  import fifo_async_pkg::*;
  #(
    parameter int PTR_W = DEF_ADDR_W + 1
  )
  (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [PTR_W-1:0] gray_i,
    output logic [PTR_W-1:0] bin_o
  );

  logic [PTR_W-1:0]     gray_meta;
  logic [PTR_W-1:0]     gray_sync;
  logic [MAX_PTR_W-1:0] bin_full;

  // first stage may go metastable, second stage is the one used here
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gray_meta <= '0;
      gray_sync <= '0;
    end else begin
      gray_meta <= gray_i;
      gray_sync <= gray_meta;
    end
  end

  // back to binary for the level subtraction in this domain
  assign bin_full = gray2bin(MAX_PTR_W'(gray_sync));
  assign bin_o    = bin_full[PTR_W-1:0];

endmodule

//--- source/gray_counter.sv
`timescale 1ns/1ps

module gray_counter
  import fifo_async_pkg::*;
  #(
    parameter int PTR_W = DEF_ADDR_W + 1
  )
  (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             inc_i,
    output logic [PTR_W-1:0] bin_o,
    output logic [PTR_W-1:0] gray_o
  );

  logic [PTR_W-1:0]     bin_next;
  logic [MAX_PTR_W-1:0] gray_next;

  assign bin_next  = bin_o + 1'b1;
  // gray is computed from the next binary value so both copies update together
  assign gray_next = bin2gray(MAX_PTR_W'(bin_next));

  // msb of the count is the wrap bit
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bin_o  <= '0;
      gray_o <= '0;
    end else if (inc_i) begin
      bin_o  <= bin_next;
      gray_o <= gray_next[PTR_W-1:0];
    end
  end

  // the crossing is only safe if at most one bit flips per step
  a_gray_one_bit: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $countones(gray_o ^ $past(gray_o)) <= 1
  ) else $error("gray_counter: gray_o changed more than one bit");

endmodule

//--- source/fifo_async_pkg.sv
package fifo_async_pkg;

  // default word width and address width, depth is 2**DEF_ADDR_W words
  localparam int DEF_DATA_W = 16;
  localparam int DEF_ADDR_W = 4;

  // widest pointer the conversion functions handle, callers truncate
  localparam int MAX_PTR_W = 32;

  function automatic logic [MAX_PTR_W-1:0] bin2gray(input logic [MAX_PTR_W-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at and above it
  function automatic logic [MAX_PTR_W-1:0] gray2bin(input logic [MAX_PTR_W-1:0] gray);
    logic [MAX_PTR_W-1:0] bin;
    bin[MAX_PTR_W-1] = gray[MAX_PTR_W-1];
    for (int i = MAX_PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage
